// ==== hdl/cache_pkg.sv ====
/*
  cache_pkg: address split, widths, memory latency and state types
  shared by the two-port read cache subsystem
*/
`default_nettype none

package cache_pkg;

  // ----------------------------------------
  // address split: tag | index | byte offset
  localparam int ADDR_W   = 16;
  localparam int TAG_W    = 9;
  localparam int INDEX_W  = 5;
  localparam int OFFSET_W = 2;
  localparam int NUM_SETS = 2 ** INDEX_W;

  // ----------------------------------------
  // word memory
  localparam int WORD_W      = 32;
  localparam int WORD_ADDR_W = ADDR_W - OFFSET_W; // tag and index
  localparam int MEM_LATENCY = 3;                 // first strobe cycle to ack

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [7:0]             byte_t;
  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

  typedef enum logic [1:0] {CS_RUN, CS_FETCH, CS_FILL} cache_state_e;

  typedef enum logic [1:0] {OWN_NONE, OWN_0, OWN_1} arb_owner_e;

endpackage

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
/*
  cache_ctrl: 2-way set-associative read cache, one byte per request,
  two-stage lookup and a single-word refill from the shared memory
*/
`default_nettype none

module cache_ctrl (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   req_valid,
  input  wire cache_pkg::addr_t req_addr,
  output logic                  req_ready,
  output logic                  resp_valid,
  output cache_pkg::byte_t      resp_data,
  input  wire                   resp_ready,
  output logic                  mem_stb,
  output cache_pkg::word_addr_t mem_addr,
  input  wire cache_pkg::word_t mem_data,
  input  wire                   mem_ack
);

  cache_pkg::cache_state_e state;

  logic [cache_pkg::TAG_W-1:0]    req_tag;
  logic [cache_pkg::INDEX_W-1:0]  req_index;
  logic [cache_pkg::OFFSET_W-1:0] req_offset;

  // lookup stage buffers
  logic                           valid_buf;
  logic [cache_pkg::TAG_W-1:0]    tag_buf;
  logic [cache_pkg::INDEX_W-1:0]  index_buf;
  logic [cache_pkg::OFFSET_W-1:0] offset_buf;

  // line storage, indexed by way then set
  logic [cache_pkg::NUM_SETS-1:0] valid_arr [2];
  logic [cache_pkg::TAG_W-1:0]    tag_arr   [2][cache_pkg::NUM_SETS];
  cache_pkg::word_t               data_arr  [2][cache_pkg::NUM_SETS];
  logic [cache_pkg::NUM_SETS-1:0] lru;      // way to replace next

  // tag-read stage outputs
  logic [1:0]                     valid_out;
  logic [cache_pkg::TAG_W-1:0]    tag_out  [2];
  cache_pkg::word_t               data_out [2];

  logic [1:0]       way_hit;
  logic             hit;
  cache_pkg::word_t hit_word;
  cache_pkg::word_t fill_word;
  logic             fill_way;

  assign req_tag    = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_index  = req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign req_offset = req_addr[cache_pkg::OFFSET_W-1:0];

  // ----------------------------------------
  // hit detection and byte select

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_out[w] && (tag_out[w] == tag_buf);
    end
  end

  assign hit      = |way_hit;
  assign hit_word = way_hit[1] ? data_out[1] : data_out[0];

  always_comb begin
    case (offset_buf)
      2'd0:    resp_data = hit_word[31:24]; // big-endian byte order
      2'd1:    resp_data = hit_word[23:16];
      2'd2:    resp_data = hit_word[15:8];
      default: resp_data = hit_word[7:0];
    endcase
  end

  assign resp_valid = valid_buf && hit && (state == cache_pkg::CS_RUN);
  // stage advances when empty or when its hit is taken
  assign req_ready  = (state == cache_pkg::CS_RUN) && (!valid_buf || (hit && resp_ready));

  assign mem_stb  = (state == cache_pkg::CS_FETCH);
  assign mem_addr = {tag_buf, index_buf};
  assign fill_way = lru[index_buf];

  // ----------------------------------------
  // control state

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= cache_pkg::CS_RUN;
      valid_buf <= 1'b0;
      valid_out <= '0;
      lru       <= '0;
      valid_arr <= '{default: '0};
    end else begin
      if (req_ready) begin
        valid_buf <= req_valid;
        valid_out <= {valid_arr[1][req_index], valid_arr[0][req_index]};
      end
      case (state)
        cache_pkg::CS_RUN: begin
          if (valid_buf && hit) begin
            lru[index_buf] <= ~way_hit[1]; // other way becomes LRU
          end else if (valid_buf) begin
            state <= cache_pkg::CS_FETCH;
          end
        end
        cache_pkg::CS_FETCH: begin
          if (mem_ack) begin
            state <= cache_pkg::CS_FILL;
          end
        end
        cache_pkg::CS_FILL: begin
          valid_arr[fill_way][index_buf] <= 1'b1;
          valid_out[fill_way]            <= 1'b1; // lookup replays as a hit
          lru[index_buf]                 <= ~fill_way;
          state                          <= cache_pkg::CS_RUN;
        end
        default: state <= cache_pkg::CS_RUN;
      endcase
    end
  end

  // ----------------------------------------
  // tags, data and pipeline payload

  always_ff @(posedge clk) begin
    if (req_ready) begin
      tag_buf    <= req_tag;
      index_buf  <= req_index;
      offset_buf <= req_offset;
      for (int w = 0; w < 2; w++) begin
        tag_out[w]  <= tag_arr[w][req_index];
        data_out[w] <= data_arr[w][req_index];
      end
    end
    if (state == cache_pkg::CS_FETCH && mem_ack) begin
      fill_word <= mem_data;
    end
    if (state == cache_pkg::CS_FILL) begin
      tag_arr[fill_way][index_buf]  <= tag_buf;
      data_arr[fill_way][index_buf] <= fill_word;
      tag_out[fill_way]             <= tag_buf;
      data_out[fill_way]            <= fill_word;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
/*
  mem_arbiter: round-robin arbiter giving the shared word memory bus
  to one cache port at a time, held until that port's ack
*/
`default_nettype none

module mem_arbiter (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        stb0,
  input  wire cache_pkg::word_addr_t addr0,
  output cache_pkg::word_t           data0,
  output logic                       ack0,
  input  wire                        stb1,
  input  wire cache_pkg::word_addr_t addr1,
  output cache_pkg::word_t           data1,
  output logic                       ack1,
  output logic                       mem_stb,
  output cache_pkg::word_addr_t      mem_addr,
  input  wire cache_pkg::word_t      mem_data,
  input  wire                        mem_ack
);

  cache_pkg::arb_owner_e owner;
  logic                  prev_was_1; // port 1 had the bus last

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner      <= cache_pkg::OWN_NONE;
      prev_was_1 <= 1'b1; // so port 0 wins first
    end else begin
      case (owner)
        cache_pkg::OWN_NONE: begin
          if (stb0 && (!stb1 || prev_was_1)) begin
            owner      <= cache_pkg::OWN_0;
            prev_was_1 <= 1'b0;
          end else if (stb1) begin
            owner      <= cache_pkg::OWN_1;
            prev_was_1 <= 1'b1;
          end
        end
        default: begin
          if (mem_ack) owner <= cache_pkg::OWN_NONE; // free again next cycle
        end
      endcase
    end
  end

  assign mem_stb  = (owner == cache_pkg::OWN_0 && stb0) || (owner == cache_pkg::OWN_1 && stb1);
  assign mem_addr = (owner == cache_pkg::OWN_1) ? addr1 : addr0;

  assign data0 = mem_data;
  assign data1 = mem_data;
  assign ack0  = mem_ack && (owner == cache_pkg::OWN_0);
  assign ack1  = mem_ack && (owner == cache_pkg::OWN_1);

endmodule

`default_nettype wire

// ==== hdl/word_memory.sv ====
/*
  word_memory: shared word store with a fixed-latency strobe/ack read
  port and a one-word-per-clock boot-load port
*/
`default_nettype none

module word_memory (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        stb,
  input  wire cache_pkg::word_addr_t addr,
  output cache_pkg::word_t           data,
  output logic                       ack,
  input  wire                        load_en,
  input  wire cache_pkg::word_addr_t load_addr,
  input  wire cache_pkg::word_t      load_data
);

  cache_pkg::word_t mem [2 ** cache_pkg::WORD_ADDR_W];

  logic [$clog2(cache_pkg::MEM_LATENCY)-1:0] cnt; // zero when idle

  initial begin
    for (int i = 0; i < 2 ** cache_pkg::WORD_ADDR_W; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      ack <= 1'b0;
    end else begin
      ack <= 1'b0;
      if (cnt == $bits(cnt)'(cache_pkg::MEM_LATENCY - 1)) begin
        cnt <= '0;
        ack <= 1'b1;
      end else if (cnt != '0) begin
        cnt <= cnt + 1'b1;
      end else if (stb && !ack) begin
        cnt <= $bits(cnt)'(1); // new strobe
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cnt == $bits(cnt)'(cache_pkg::MEM_LATENCY - 1)) data <= mem[addr];
    if (load_en) mem[load_addr] <= load_data;
  end

endmodule

`default_nettype wire

// ==== hdl/cache_subsys_top.sv ====
/*
  cache_subsys_top: two read caches sharing one word memory
  through a round-robin arbiter
*/
`default_nettype none

module cache_subsys_top (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        req_valid_0,
  input  wire cache_pkg::addr_t      req_addr_0,
  output logic                       req_ready_0,
  output logic                       resp_valid_0,
  output cache_pkg::byte_t           resp_data_0,
  input  wire                        resp_ready_0,
  input  wire                        req_valid_1,
  input  wire cache_pkg::addr_t      req_addr_1,
  output logic                       req_ready_1,
  output logic                       resp_valid_1,
  output cache_pkg::byte_t           resp_data_1,
  input  wire                        resp_ready_1,
  input  wire                        load_en,
  input  wire cache_pkg::word_addr_t load_addr,
  input  wire cache_pkg::word_t      load_data
);

  // ----------------------------------------
  // cache side of the arbiter
  logic                  c0_stb, c0_ack, c1_stb, c1_ack;
  cache_pkg::word_addr_t c0_addr, c1_addr;
  cache_pkg::word_t      c0_data, c1_data;

  // memory side
  logic                  m_stb, m_ack;
  cache_pkg::word_addr_t m_addr;
  cache_pkg::word_t      m_data;

  cache_ctrl cache0_i (
    .clk, .arst_n,
    .req_valid (req_valid_0), .req_addr (req_addr_0), .req_ready (req_ready_0),
    .resp_valid (resp_valid_0), .resp_data (resp_data_0), .resp_ready (resp_ready_0),
    .mem_stb (c0_stb), .mem_addr (c0_addr), .mem_data (c0_data), .mem_ack (c0_ack)
  );

  cache_ctrl cache1_i (
    .clk, .arst_n,
    .req_valid (req_valid_1), .req_addr (req_addr_1), .req_ready (req_ready_1),
    .resp_valid (resp_valid_1), .resp_data (resp_data_1), .resp_ready (resp_ready_1),
    .mem_stb (c1_stb), .mem_addr (c1_addr), .mem_data (c1_data), .mem_ack (c1_ack)
  );

  mem_arbiter arb_i (
    .clk, .arst_n,
    .stb0 (c0_stb), .addr0 (c0_addr), .data0 (c0_data), .ack0 (c0_ack),
    .stb1 (c1_stb), .addr1 (c1_addr), .data1 (c1_data), .ack1 (c1_ack),
    .mem_stb (m_stb), .mem_addr (m_addr), .mem_data (m_data), .mem_ack (m_ack)
  );

  word_memory mem_i (
    .clk, .arst_n,
    .stb (m_stb), .addr (m_addr), .data (m_data), .ack (m_ack),
    .load_en, .load_addr, .load_data
  );

endmodule

`default_nettype wire

// ==== verification/cache_chk.sv ====
/*
  cache_chk: handshake and memory bus assertions for the cache and arbiter
*/
`default_nettype none

module cache_chk (
  input wire                        clk,
  input wire                        arst_n,
  input wire                        stb,
  input wire cache_pkg::word_addr_t addr,
  input wire                        ack,
  input wire                        ack_ok,
  input wire                        resp_valid,
  input wire                        resp_ready,
  input wire cache_pkg::byte_t      resp_data
);
  timeunit 1ns;
  timeprecision 100ps;

  stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
    stb && !ack |=> stb && $stable(addr))
    else $error("strobe or address changed before ack");

  resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
    else $error("response changed under back-pressure");

  ack_owner: assert property (@(posedge clk) disable iff (!arst_n) ack_ok)
    else $error("ack routed to a port that does not own the bus");

  reset_idle: assert property (@(posedge clk) !arst_n |-> !resp_valid)
    else $error("response valid during reset");

endmodule

bind cache_ctrl cache_chk ctrl_chk_i (
  .clk, .arst_n, .stb (mem_stb), .addr (mem_addr), .ack (mem_ack),
  .ack_ok (!mem_ack || mem_stb),
  .resp_valid, .resp_ready, .resp_data
);

bind mem_arbiter cache_chk arb_chk_i (
  .clk, .arst_n, .stb (mem_stb), .addr (mem_addr), .ack (mem_ack),
  .ack_ok ((!ack0 || (stb0 && !prev_was_1)) && (!ack1 || (stb1 && prev_was_1))),
  .resp_valid (1'b0), .resp_ready (1'b1), .resp_data (8'h00)
);

`default_nettype wire

// ==== verification/cache_tb.sv ====
/*
  cache_tb: random two-port reads against a model of memory, tags and LRU
*/
`default_nettype none

module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_LOAD    = 64;
  localparam int N_RAND    = 400;
  localparam int N_LRU     = 16;
  localparam int N_MISS    = 8;
  localparam int TOTAL_REQ = 2 * (N_RAND + N_LRU + N_MISS);
  localparam int LIMIT_CYC = TOTAL_REQ * (cache_pkg::MEM_LATENCY + 20) + N_LOAD + 60;

  logic                  clk;
  logic                  arst_n;
  logic                  req_valid  [2];
  cache_pkg::addr_t      req_addr   [2];
  logic                  req_ready  [2];
  logic                  resp_valid [2];
  cache_pkg::byte_t      resp_data  [2];
  logic                  resp_ready [2];
  logic                  load_en;
  cache_pkg::word_addr_t load_addr;
  cache_pkg::word_t      load_data;

  int seed = 30046;
  int cyc = 0;
  int errors = 0;
  int total_resp = 0;

  // ----------------------------------------
  // reference model state
  cache_pkg::word_t      model_mem [2 ** cache_pkg::WORD_ADDR_W];
  cache_pkg::word_addr_t loaded    [N_LOAD];
  logic                  m_valid   [2][2][cache_pkg::NUM_SETS]; // port, way, set
  logic [cache_pkg::TAG_W-1:0] m_tag [2][2][cache_pkg::NUM_SETS];
  logic                  m_lru     [2][cache_pkg::NUM_SETS];

  // outstanding requests per port in acceptance order
  cache_pkg::byte_t exp_byte [2][512];
  logic             exp_hit  [2][512];
  int               exp_edge [2][512];
  int               wr_ptr   [2];
  int               rd_ptr   [2];
  int               lat      [2];
  logic             rise_seen [2];

  cache_subsys_top dut_i (
    .clk, .arst_n,
    .req_valid_0 (req_valid[0]), .req_addr_0 (req_addr[0]), .req_ready_0 (req_ready[0]),
    .resp_valid_0 (resp_valid[0]), .resp_data_0 (resp_data[0]),
    .resp_ready_0 (resp_ready[0]),
    .req_valid_1 (req_valid[1]), .req_addr_1 (req_addr[1]), .req_ready_1 (req_ready[1]),
    .resp_valid_1 (resp_valid[1]), .resp_data_1 (resp_data[1]),
    .resp_ready_1 (resp_ready[1]),
    .load_en, .load_addr, .load_data
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic int rnd(input int range);
    int r;
    r = $random(seed);
    return ((r % range) + range) % range;
  endfunction

  function automatic cache_pkg::byte_t model_byte(input cache_pkg::addr_t a);
    cache_pkg::word_t w;
    w = model_mem[a[15:2]];
    return cache_pkg::byte_t'(w >> (8 * (3 - int'(a[1:0])))); // offset 0 is the top byte
  endfunction

  // lookup and update of one port's tags and LRU giving the hit flag
  function automatic logic model_access(input int p, input cache_pkg::addr_t a);
    logic [cache_pkg::TAG_W-1:0]   tag;
    logic [cache_pkg::INDEX_W-1:0] idx;
    logic                          way;
    logic                          hit;
    tag = a[15:7];
    idx = a[6:2];
    hit = 1'b0;
    way = m_lru[p][idx];
    for (int w = 0; w < 2; w++) begin
      if (m_valid[p][w][idx] && m_tag[p][w][idx] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      m_valid[p][way][idx] = 1'b1;
      m_tag[p][way][idx]   = tag;
    end
    m_lru[p][idx] = ~way;
    return hit;
  endfunction

  function automatic cache_pkg::addr_t gen_addr(input int p, input int mode, input int k);
    int tags[8] = '{1, 2, 1, 3, 2, 1, 3, 3}; // A B A C B A C C at one index
    case (mode)
      0: begin
        if (rnd(10) < 7) return {loaded[rnd(N_LOAD)], 2'(rnd(4))};
        return cache_pkg::addr_t'(rnd(65536));
      end
      1: return {9'(100 + tags[k % 8]), 5'd9, 2'(rnd(4))};
      default: return {loaded[k + p * N_MISS], 2'(rnd(4))}; // distinct loaded words per port
    endcase
  endfunction

  task automatic check_byte(input cache_pkg::byte_t exp, input cache_pkg::byte_t act,
                            input int p);
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t: resp_data_%0d expected %h got %h", $time, p, exp, act);
    end
  endtask

  task automatic check_hit(input logic exp, input int latency, input int p);
    logic got;
    got = (latency == 1);
    if (exp !== got) begin
      errors++;
      $display("mismatch at %0t: resp_valid_%0d hit expected %0b got %0b (latency %0d)",
               $time, p, exp, got, latency);
    end
  endtask

  // ----------------------------------------
  // one test of n requests per port, sampled at negedge and driven at posedge
  task automatic run_phase(input string name, input int mode, input int n);
    int   gen  [2];
    int   done [2];
    int   err0;
    logic take [2];
    err0 = errors;
    for (int p = 0; p < 2; p++) begin
      gen[p]       = 0;
      done[p]      = 0;
      wr_ptr[p]    = 0;
      rd_ptr[p]    = 0;
      rise_seen[p] = 1'b0;
    end
    while (done[0] < n || done[1] < n) begin
      @(negedge clk);
      for (int p = 0; p < 2; p++) begin
        if (resp_valid[p] && !rise_seen[p] && rd_ptr[p] < wr_ptr[p]) begin
          lat[p]       = cyc - exp_edge[p][rd_ptr[p]] + 1;
          rise_seen[p] = 1'b1;
        end
        if (resp_valid[p] && resp_ready[p]) begin
          if (rd_ptr[p] == wr_ptr[p]) begin
            errors++;
            $display("port %0d returned a response with no request outstanding", p);
          end else begin
            check_byte(exp_byte[p][rd_ptr[p]], resp_data[p], p);
            check_hit(exp_hit[p][rd_ptr[p]], lat[p], p);
            rd_ptr[p]++;
          end
          done[p]++;
          rise_seen[p] = 1'b0;
        end
        take[p] = req_valid[p] && req_ready[p];
        if (take[p]) begin
          exp_byte[p][wr_ptr[p]] = model_byte(req_addr[p]);
          exp_hit[p][wr_ptr[p]]  = model_access(p, req_addr[p]);
          exp_edge[p][wr_ptr[p]] = cyc + 1; // accepted at the coming edge
          wr_ptr[p]++;
        end
      end
      @(posedge clk);
      for (int p = 0; p < 2; p++) begin
        if (take[p] || !req_valid[p]) begin
          if (gen[p] < n && (mode != 0 || rnd(4) != 0)) begin
            req_addr[p]  <= gen_addr(p, mode, gen[p]);
            req_valid[p] <= 1'b1;
            gen[p]++;
          end else begin
            req_valid[p] <= 1'b0;
          end
        end
        resp_ready[p] <= (mode != 0) || (rnd(10) < 7);
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (rd_ptr[p] != wr_ptr[p]) begin
        errors++;
        $display("port %0d has %0d requests without a response", p, wr_ptr[p] - rd_ptr[p]);
      end
      total_resp += done[p];
    end
    $display("test %s: %0d responses per port, %0d errors", name, n, errors - err0);
  endtask

  initial begin
    cache_pkg::word_addr_t a;
    cache_pkg::word_t      d;
    arst_n    = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (int p = 0; p < 2; p++) begin
      req_valid[p]  = 1'b0;
      req_addr[p]   = '0;
      resp_ready[p] = 1'b0;
      for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
        m_lru[p][s]      = 1'b0;
        m_valid[p][0][s] = 1'b0;
        m_valid[p][1][s] = 1'b0;
      end
    end
    for (int i = 0; i < 2 ** cache_pkg::WORD_ADDR_W; i++) model_mem[i] = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < N_LOAD; i++) begin
      @(posedge clk);
      a = cache_pkg::word_addr_t'(rnd(2 ** cache_pkg::WORD_ADDR_W));
      d = cache_pkg::word_t'($random(seed));
      load_en      <= 1'b1;
      load_addr    <= a;
      load_data    <= d;
      model_mem[a] = d;
      loaded[i]    = a;
    end
    @(posedge clk);
    load_en <= 1'b0;
    run_phase("simultaneous misses on both ports", 2, N_MISS);
    run_phase("random reads with back-pressure", 0, N_RAND);
    run_phase("lru eviction at one index", 1, N_LRU);
    $display("%0d responses checked, %0d errors", total_resp, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(LIMIT_CYC * 8);
    $display("timeout: responses did not complete within %0d cycles", LIMIT_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/mem_arbiter.sv
hdl/word_memory.sv
hdl/cache_subsys_top.sv
verification/cache_chk.sv
verification/cache_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: run clean

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee /dev/stderr | grep -q 'ALL CHECKS PASSED'

obj_dir/Vcache_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module cache_tb -f sim.f -o Vcache_tb

clean:
	rm -rf obj_dir
